//--- cpu_pkg.sv
// Shared types for the MIPS subset core; only the listed opcodes and function codes are decoded
package cpu_pkg;

    // Primary opcode field
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        F_SLL = 6'h00,
        F_SRL = 6'h02,
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_e      funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     op;
        logic [25:0] target26;
    } j_fmt_t;

    // One instruction word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic    reg_dst;       // rd is the destination, else rt
        logic    alu_src_imm;
        logic    alu_src_shamt;
        logic    sign_ext;
        logic    mem_to_reg;
        logic    mem_wr;
        logic    reg_wr;
        logic    branch;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;      // Byte address
        logic [31:0] data;
    } mem_wr_t;

endpackage

//--- alu.sv
// 32-bit ALU; SLT compares signed, shifts use the low five bits of b_i
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  alu_op_e     op_i,
    output logic [31:0] result_o,
    output logic        zero_o
);

    logic [4:0] shift_amt;

    assign shift_amt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = a_i << shift_amt;
            ALU_SRL: result_o = a_i >> shift_amt;  // Logical, zero fill
            default: result_o = '0;
        endcase
    end

    // BEQ looks at this after a subtract
    assign zero_o = (result_o == '0);

endmodule

//--- regfile.sv
// 32 x 32 register file, combinational reads, write at the clock edge; register 0 is hardwired zero
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin  // Writes to r0 are dropped
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, a write shows up on the next cycle
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

    a_r0_zero: assert property (@(posedge clk) disable iff (rst_i)
        ((raddr_a_i == 5'd0) -> (rdata_a_o == '0)) &&
        ((raddr_b_i == 5'd0) -> (rdata_b_o == '0)))
        else $error("regfile: register 0 read nonzero");

endmodule

//--- decode_ctrl.sv
// Instruction decoder and control generation; unsupported encodings decode as no-ops
`timescale 1ns/1ps

module decode_ctrl import cpu_pkg::*; (
    input  instr_u      instr_i,
    output ctrl_t       ctrl_o,
    output logic [4:0]  rs_o,
    output logic [4:0]  rt_o,
    output logic [4:0]  rd_o,
    output logic [4:0]  shamt_o,
    output logic [31:0] imm_ext_o
);

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        case (instr_i.r.op)
            OP_RTYPE: begin
                ctrl_o.reg_dst = 1'b1;
                ctrl_o.reg_wr  = 1'b1;
                case (instr_i.r.funct)
                    F_ADD: ctrl_o.alu_op = ALU_ADD;
                    F_SUB: ctrl_o.alu_op = ALU_SUB;
                    F_AND: ctrl_o.alu_op = ALU_AND;
                    F_OR:  ctrl_o.alu_op = ALU_OR;
                    F_SLT: ctrl_o.alu_op = ALU_SLT;
                    F_SLL: begin
                        ctrl_o.alu_op        = ALU_SLL;
                        ctrl_o.alu_src_shamt = 1'b1;
                    end
                    F_SRL: begin
                        ctrl_o.alu_op        = ALU_SRL;
                        ctrl_o.alu_src_shamt = 1'b1;
                    end
                    default: ctrl_o.reg_wr = 1'b0;
                endcase
            end
            OP_ADDI: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.sign_ext    = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
            end
            OP_ANDI: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
                ctrl_o.alu_op      = ALU_AND;
            end
            OP_ORI: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
                ctrl_o.alu_op      = ALU_OR;
            end
            OP_LW: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.sign_ext    = 1'b1;
                ctrl_o.mem_to_reg  = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
            end
            OP_SW: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.sign_ext    = 1'b1;
                ctrl_o.mem_wr      = 1'b1;
            end
            OP_BEQ: begin
                ctrl_o.branch   = 1'b1;
                ctrl_o.sign_ext = 1'b1;
                ctrl_o.alu_op   = ALU_SUB;  // Equal operands give zero
            end
            OP_J:    ctrl_o.jump = 1'b1;
            default: ctrl_o.alu_op = ALU_ADD;
        endcase
    end

    // Shifts operate on rt, so port A reads rt for them
    assign rs_o    = ctrl_o.alu_src_shamt ? instr_i.r.rt : instr_i.r.rs;
    assign rt_o    = instr_i.i.rt;
    assign rd_o    = instr_i.r.rd;
    assign shamt_o = instr_i.r.shamt;

    always_comb begin
        if (ctrl_o.jump) begin
            imm_ext_o = {6'b0, instr_i.j.target26};  // Raw target, fetch adds the region bits
        end else if (ctrl_o.sign_ext) begin
            imm_ext_o = {{16{instr_i.i.imm16[15]}}, instr_i.i.imm16};
        end else begin
            imm_ext_o = {16'b0, instr_i.i.imm16};
        end
    end

endmodule

//--- fetch_unit.sv
// PC and instruction memory; the PC wraps modulo IMEM_WORDS, which must be a power of two
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
    parameter int  IMEM_WORDS = 64,
    localparam int IA_W       = $clog2(IMEM_WORDS)
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            imem_we_i,
    input  logic [IA_W-1:0] imem_addr_i,
    input  instr_u          imem_data_i,
    input  ctrl_t           ctrl_i,
    input  logic            zero_i,
    input  logic [31:0]     imm_ext_i,
    output logic [31:0]     pc_o,
    output logic [31:0]     pc_plus4_o,
    output instr_u          instr_o
);

    logic [31:0]     pc_q;
    logic [31:0]     pc_next;
    logic [31:0]     branch_pc;
    logic [31:0]     jump_pc;
    logic [IA_W-1:0] fetch_idx;

    instr_u imem [IMEM_WORDS];

    // Load port, used by the testbench while the core is held in reset
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    assign fetch_idx = pc_q[IA_W+1:2];  // Word index, upper PC bits dropped
    assign instr_o   = imem[fetch_idx];

    assign pc_o       = pc_q;
    assign pc_plus4_o = pc_q + 32'd4;

    always_comb begin
        branch_pc = pc_plus4_o + {imm_ext_i[29:0], 2'b00};
        jump_pc   = {pc_plus4_o[31:28], imm_ext_i[25:0], 2'b00};  // Region bits first
        if (ctrl_i.jump) begin
            pc_next = jump_pc;
        end else if (ctrl_i.branch && zero_i) begin
            pc_next = branch_pc;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Branch offsets and jump targets both keep the low bits clear
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch_unit: PC %h not word aligned", pc_q);

endmodule

//--- data_mem.sv
// Word-only data memory, index wraps modulo DMEM_WORDS (power of two); no byte or halfword access
`timescale 1ns/1ps

module data_mem import cpu_pkg::*; #(
    parameter int  DMEM_WORDS = 64,
    localparam int DA_W       = $clog2(DMEM_WORDS)
) (
    input  logic        clk,
    input  ctrl_t       ctrl_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [31:0] alu_result_i,
    output logic [31:0] wb_data_o,
    output mem_wr_t     mem_wr_o
);

    logic [31:0]     mem [DMEM_WORDS];
    logic [DA_W-1:0] word_idx;

    assign word_idx = addr_i[DA_W+1:2];

    always_comb begin
        mem_wr_o.valid = ctrl_i.mem_wr;
        mem_wr_o.addr  = addr_i;
        mem_wr_o.data  = wdata_i;
    end

    always_ff @(posedge clk) begin
        if (mem_wr_o.valid) begin
            mem[word_idx] <= mem_wr_o.data;  // Full word, no strobes
        end
    end

    // Write-back select
    assign wb_data_o = ctrl_i.mem_to_reg ? mem[word_idx] : alu_result_i;

    // Base register plus offset must land on a word boundary
    a_store_aligned: assert property (@(posedge clk)
        ctrl_i.mem_wr |-> (addr_i[1:0] == 2'b00))
        else $error("data_mem: store to unaligned address %h", addr_i);

endmodule

//--- cpu_top.sv
// Single-cycle MIPS subset core; no back-pressure, commit ports show the write of the next edge
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  instr_u                        imem_data_i,
    output logic [31:0]                   trace_pc_o,
    output reg_wr_t                       reg_wr_o,
    output mem_wr_t                       mem_wr_o
);

    instr_u      instr;
    ctrl_t       ctrl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [4:0]  wr_addr;
    logic [31:0] imm_ext;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] wb_data;

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .ctrl_i      (ctrl),
        .zero_i      (alu_zero),
        .imm_ext_i   (imm_ext),
        .pc_o        (trace_pc_o),
        .pc_plus4_o  (),
        .instr_o     (instr)
    );

    decode_ctrl dec0 (
        .instr_i   (instr),
        .ctrl_o    (ctrl),
        .rs_o      (rs),
        .rt_o      (rt),
        .rd_o      (rd),
        .shamt_o   (shamt),
        .imm_ext_o (imm_ext)
    );

    assign wr_addr = ctrl.reg_dst ? rd : rt;

    regfile rf0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .we_i      (ctrl.reg_wr),
        .waddr_i   (wr_addr),
        .wdata_i   (wb_data),
        .raddr_a_i (rs),
        .raddr_b_i (rt),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    // Operand B: shift amount, immediate or rt
    always_comb begin
        if (ctrl.alu_src_shamt) begin
            alu_b = {27'b0, shamt};
        end else if (ctrl.alu_src_imm) begin
            alu_b = imm_ext;
        end else begin
            alu_b = rdata_b;
        end
    end

    alu alu0 (
        .a_i      (rdata_a),
        .b_i      (alu_b),
        .op_i     (ctrl.alu_op),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem0 (
        .clk          (clk),
        .ctrl_i       (ctrl),
        .addr_i       (alu_result),
        .wdata_i      (rdata_b),
        .alu_result_i (alu_result),
        .wb_data_o    (wb_data),
        .mem_wr_o     (mem_wr_o)
    );

    // Commit report, r0 writes are not architectural
    always_comb begin
        reg_wr_o.valid = ctrl.reg_wr && (wr_addr != 5'd0);
        reg_wr_o.addr  = wr_addr;
        reg_wr_o.data  = wb_data;
    end

    a_opcode_known: assert property (@(posedge clk) disable iff (rst_i)
        instr.r.op inside {OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI, OP_LW, OP_SW, OP_BEQ, OP_J})
        else $error("cpu_top: unsupported opcode %h at PC %h", instr.r.op, trace_pc_o);

endmodule

//--- tb_cpu.sv
// Random program testbench; LW and SW stay inside an 8-word window that the prologue fills first
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ;

    localparam int          IMEM_WORDS   = 64;
    localparam int          DMEM_WORDS   = 64;
    localparam int          NUM_PROGRAMS = 3;
    localparam int          RUN_TIMEOUT  = 4 * IMEM_WORDS;
    localparam logic [31:0] SEED         = 32'h40143a1e;

    logic                          clk;
    logic                          rst_i;
    logic                          imem_we_i;
    logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i;
    instr_u                        imem_data_i;
    logic [31:0]                   trace_pc_o;
    reg_wr_t                       reg_wr_o;
    mem_wr_t                       mem_wr_o;

    instr_u      prog [IMEM_WORDS];
    int          prog_len;
    logic [31:0] model_pc;
    logic [31:0] model_regs [32];
    logic [31:0] model_dmem [DMEM_WORDS];

    cpu_top #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) dut0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .trace_pc_o  (trace_pc_o),
        .reg_wr_o    (reg_wr_o),
        .mem_wr_o    (mem_wr_o)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pc(input string name, input logic [31:0] want, input logic [31:0] got);
        if (got !== want) begin
            $display("Error at time %0t: %s expected %h, got %h", $time, name, want, got);
            stop_run();
        end
    endtask

    task automatic check_reg_wr(input string name, input reg_wr_t want, input reg_wr_t got);
        if ((got.valid !== want.valid) ||
            (want.valid && ((got.addr !== want.addr) || (got.data !== want.data)))) begin
            $display("Error at time %0t: %s expected valid=%0b addr=%0d data=%h, %s",
                     $time, name, want.valid, want.addr, want.data,
                     $sformatf("got valid=%0b addr=%0d data=%h", got.valid, got.addr, got.data));
            stop_run();
        end
    endtask

    task automatic check_mem_wr(input string name, input mem_wr_t want, input mem_wr_t got);
        if ((got.valid !== want.valid) ||
            (want.valid && ((got.addr !== want.addr) || (got.data !== want.data)))) begin
            $display("Error at time %0t: %s expected valid=%0b addr=%h data=%h, %s",
                     $time, name, want.valid, want.addr, want.data,
                     $sformatf("got valid=%0b addr=%h data=%h", got.valid, got.addr, got.data));
            stop_run();
        end
    endtask

    function automatic instr_u enc_r(input funct_e f, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd,
                                     input logic [4:0] shamt);
        instr_u w;
        w.r.op    = OP_RTYPE;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.rd    = rd;
        w.r.shamt = shamt;
        w.r.funct = f;
        return w;
    endfunction

    function automatic instr_u enc_i(input opcode_e op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
        instr_u w;
        w.i.op    = op;
        w.i.rs    = rs;
        w.i.rt    = rt;
        w.i.imm16 = imm;
        return w;
    endfunction

    function automatic instr_u enc_j(input logic [25:0] target);
        instr_u w;
        w.j.op       = OP_J;
        w.j.target26 = target;
        return w;
    endfunction

    task automatic gen_program();
        int         last;
        int         tgt;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rc;
        prog_len = 12 + 24 + ($urandom % 8) + 1;
        last     = prog_len - 1;
        for (int i = 0; i < 4; i++) begin
            prog[i] = enc_i(OP_ADDI, 5'd0, 5'(i + 1), 16'($urandom));  // Seed r1..r4
        end
        for (int w = 0; w < 8; w++) begin
            prog[4 + w] = enc_i(OP_SW, 5'd0, 5'($urandom % 5), 16'(4 * w));
        end
        for (int i = 12; i < last; i++) begin
            ra  = 5'($urandom % 8);
            rb  = 5'($urandom % 8);
            rc  = 5'($urandom % 8);   // r0 now and then, dropped write
            tgt = i + 1 + ($urandom % 4);
            if (tgt > last) begin
                tgt = last;
            end
            case ($urandom % 12)
                0:  prog[i] = enc_r(F_ADD, ra, rb, rc, 5'd0);
                1:  prog[i] = enc_r(F_SUB, ra, rb, rc, 5'd0);
                2:  prog[i] = enc_r(F_AND, ra, rb, rc, 5'd0);
                3:  prog[i] = enc_r(F_OR, ra, rb, rc, 5'd0);
                4:  prog[i] = enc_r(F_SLT, ra, rb, rc, 5'd0);
                5:  prog[i] = enc_r(F_SLL, 5'd0, rb, rc, 5'($urandom));
                6:  prog[i] = enc_r(F_SRL, 5'd0, rb, rc, 5'($urandom));
                7:  prog[i] = enc_i(OP_ADDI, ra, rb, 16'($urandom));
                8:  prog[i] = enc_i(($urandom % 2) ? OP_ANDI : OP_ORI, ra, rb, 16'($urandom));
                9:  prog[i] = enc_i(($urandom % 2) ? OP_LW : OP_SW, 5'd0, rb,
                                    16'(4 * ($urandom % 8)));
                10: begin
                    if ($urandom % 2) begin
                        rb = ra;   // Forces a taken branch
                    end
                    prog[i] = enc_i(OP_BEQ, ra, rb, 16'(tgt - i - 1));
                end
                default: prog[i] = enc_j(26'(tgt));
            endcase
        end
        prog[last] = enc_j(26'(last));   // Self loop ends the program
    endtask

    // ISA model, one instruction per call
    task automatic model_step(output reg_wr_t rw, output mem_wr_t mw);
        instr_u      ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc4;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] next_pc;
        ins     = prog[(model_pc >> 2) % IMEM_WORDS];
        a       = model_regs[ins.r.rs];
        b       = model_regs[ins.r.rt];
        pc4     = model_pc + 32'd4;
        sext    = {{16{ins.i.imm16[15]}}, ins.i.imm16};
        addr    = a + sext;
        next_pc = pc4;
        rw      = '0;
        mw      = '0;
        case (ins.r.op)
            OP_RTYPE: begin
                rw.valid = 1'b1;
                rw.addr  = ins.r.rd;
                case (ins.r.funct)
                    F_ADD:   rw.data = a + b;
                    F_SUB:   rw.data = a - b;
                    F_AND:   rw.data = a & b;
                    F_OR:    rw.data = a | b;
                    F_SLT:   rw.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    F_SLL:   rw.data = b << ins.r.shamt;
                    F_SRL:   rw.data = b >> ins.r.shamt;
                    default: rw.valid = 1'b0;
                endcase
            end
            OP_ADDI: rw = '{valid: 1'b1, addr: ins.i.rt, data: a + sext};
            OP_ANDI: rw = '{valid: 1'b1, addr: ins.i.rt, data: a & {16'h0, ins.i.imm16}};
            OP_ORI:  rw = '{valid: 1'b1, addr: ins.i.rt, data: a | {16'h0, ins.i.imm16}};
            OP_LW:   rw = '{valid: 1'b1, addr: ins.i.rt,
                            data: model_dmem[(addr >> 2) % DMEM_WORDS]};
            OP_SW: begin
                mw = '{valid: 1'b1, addr: addr, data: b};
                model_dmem[(addr >> 2) % DMEM_WORDS] = b;
            end
            OP_BEQ: begin
                if (a == b) begin
                    next_pc = pc4 + (sext << 2);
                end
            end
            OP_J:    next_pc = {pc4[31:28], ins.j.target26, 2'b00};
            default: next_pc = pc4;
        endcase
        if (rw.addr == 5'd0) begin
            rw.valid = 1'b0;
        end
        if (rw.valid) begin
            model_regs[rw.addr] = rw.data;
        end
        model_pc = next_pc;
    endtask

    task automatic run_program(input int num);
        reg_wr_t     want_rw;
        mem_wr_t     want_mw;
        logic [31:0] cur_pc;
        int          cycles;
        int          loop_seen;
        gen_program();
        @(posedge clk);
        rst_i <= 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            imem_we_i   <= 1'b1;
            imem_addr_i <= i[$clog2(IMEM_WORDS)-1:0];
            imem_data_i <= prog[i];
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        repeat (2) @(posedge clk);   // Three cycles of reset after the load
        @(negedge clk);
        check_pc("trace_pc_o", 32'd0, trace_pc_o);
        @(posedge clk);
        rst_i <= 1'b0;
        model_pc = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        cycles    = 0;
        loop_seen = 0;
        while (loop_seen < 4) begin
            @(negedge clk);
            if (cycles >= RUN_TIMEOUT) begin
                $display("Timeout: program %0d did not reach its final jump in %0d cycles",
                         num, RUN_TIMEOUT);
                stop_run();
            end
            check_pc("trace_pc_o", model_pc, trace_pc_o);
            cur_pc = model_pc;
            model_step(want_rw, want_mw);
            check_reg_wr("reg_wr_o", want_rw, reg_wr_o);
            check_mem_wr("mem_wr_o", want_mw, mem_wr_o);
            if (model_pc == cur_pc) begin
                loop_seen++;
            end
            cycles++;
        end
        // Final architectural state held in the core's register file
        for (int r = 0; r < 32; r++) begin
            check_reg_wr("register file", '{valid: 1'b1, addr: r[4:0], data: model_regs[r]},
                         '{valid: 1'b1, addr: r[4:0], data: dut0.rf0.regs[r]});
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;
        void'($urandom(SEED));
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- flist.f
cpu_pkg.sv
alu.sv
regfile.sv
decode_ctrl.sv
fetch_unit.sv
data_mem.sv
cpu_top.sv
tb_cpu.sv
